/* imuldiv_msg_pkg.sv */
// request and response message types for the iterative muldiv unit
// imported by every block that handles muldiv requests, responses or function codes
`default_nettype none

package imuldiv_msg_pkg;

  // ----------------------------------------------------------
  // data widths
  // ----------------------------------------------------------

  // one 32-bit source operand
  typedef logic [31:0] operand_t;

  // full-width response
  // multiply: signed 64-bit product
  // divide: remainder in [63:32], quotient in [31:0]
  typedef logic [63:0] result_t;

  // ----------------------------------------------------------
  // function codes
  // ----------------------------------------------------------

  // div/rem share one signed result pair, divu/remu one unsigned pair
  typedef enum logic [2:0] {
    fn_mul  = 3'd0,
    fn_div  = 3'd1,
    fn_divu = 3'd2,
    fn_rem  = 3'd3,
    fn_remu = 3'd4
  } muldiv_fn_t;

endpackage

`default_nettype wire

/* imuldiv_ctrl_pkg.sv */
// control definitions shared by the iterative multiply and divide engines
// both engines run the same idle/calc/done sequence over a fixed step count
`default_nettype none

package imuldiv_ctrl_pkg;

  // engine FSM states
  // idle: waiting for a request
  // calc: one iteration step per cycle
  // done: sign fixup, then hold result until the response transfers
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } engine_state_t;

  // step counter, 0 .. num_steps-1
  typedef logic [4:0] step_count_t;

  // one step per operand bit
  localparam int num_steps = 32;

endpackage

`default_nettype wire

/* imuldiv_mul_iter.sv */
// iterative 32-step shift-add multiplier returning the signed 64-bit product
// same valid/ready handshake and 33-cycle latency as the divider
`default_nettype none

module imuldiv_mul_iter (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_msg_pkg::operand_t req_a,
  input  imuldiv_msg_pkg::operand_t req_b,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_msg_pkg::result_t  resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  engine_state_t state;
  step_count_t   step;
  logic          res_valid;

  // product sign, magnitudes are multiplied unsigned
  logic          prod_neg;
  // multiplicand moves up one bit per step
  result_t       mcand;
  // multiplier moves down, bit 0 is the current step's bit
  operand_t      mplier;
  result_t       acc;
  result_t       result;

  logic          req_go;
  logic          resp_go;
  logic          last_step;
  operand_t      a_mag;
  operand_t      b_mag;
  result_t       addend;

  assign req_rdy     = (state == idle);
  assign resp_val    = res_valid;
  assign resp_result = result;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  assign a_mag = req_a[31] ? (~req_a + 32'd1) : req_a;
  assign b_mag = req_b[31] ? (~req_b + 32'd1) : req_b;

  assign last_step = (step == step_count_t'(num_steps - 1));
  assign addend    = mplier[0] ? mcand : '0;

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      step      <= '0;
      res_valid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req_go) begin
            state <= calc;
          end
        end
        calc: begin
          step <= step + step_count_t'(1);
          if (last_step) begin
            state <= done;
          end
        end
        done: begin
          // valid one cycle into done, dropped on transfer
          if (resp_go) begin
            state     <= idle;
            res_valid <= 1'b0;
          end else begin
            res_valid <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      prod_neg <= req_a[31] ^ req_b[31];
      mcand    <= {32'b0, a_mag};
      mplier   <= b_mag;
      acc      <= '0;
    end else if (state == calc) begin
      acc    <= acc + addend;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
    // magnitude product is at most 2^62, so negation never overflows
    if ((state == done) && !res_valid) begin
      result <= prod_neg ? (~acc + 64'd1) : acc;
    end
  end

  a_val_only_in_done: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (state == done));

endmodule

`default_nettype wire

/* imuldiv_div_iter.sv */
// iterative 32-step restoring divider with signed and unsigned modes
// result is {remainder, quotient}; valid/ready on both request and response
`default_nettype none

module imuldiv_div_iter (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_msg_pkg::muldiv_fn_t req_fn,
  input  imuldiv_msg_pkg::operand_t   req_a,
  input  imuldiv_msg_pkg::operand_t   req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_msg_pkg::result_t    resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------

  engine_state_t state;
  step_count_t   step;
  // set on the second done cycle, once the fixed-up result is stored
  logic          res_valid;

  // sign flags, only ever set for fn_div/fn_rem
  logic          a_neg;
  logic          b_neg;

  // remainder/quotient register: dividend shifts in from the bottom
  logic [64:0]   rq;
  // divisor magnitude parked above the quotient field
  logic [64:0]   divisor;
  result_t       result;

  // ----------------------------------------------------------
  // combinational
  // ----------------------------------------------------------

  logic          req_go;
  logic          resp_go;
  logic          signed_fn;
  logic          last_step;
  operand_t      a_mag;
  operand_t      b_mag;
  logic [64:0]   rq_shift;
  logic [64:0]   rq_diff;
  logic [64:0]   rq_next;
  operand_t      quot_fixed;
  operand_t      rem_fixed;

  assign req_rdy     = (state == idle);
  assign resp_val    = res_valid;
  assign resp_result = result;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // signed variants
  assign signed_fn = (req_fn == fn_div) || (req_fn == fn_rem);

  // operand magnitudes; the most negative value maps onto itself, which is right unsigned
  assign a_mag = (signed_fn && req_a[31]) ? (~req_a + 32'd1) : req_a;
  assign b_mag = (signed_fn && req_b[31]) ? (~req_b + 32'd1) : req_b;

  assign last_step = (step == step_count_t'(num_steps - 1));

  // one restoring step
  // shift, trial subtract, keep on non-negative difference
  assign rq_shift = rq << 1;
  assign rq_diff  = rq_shift - divisor;
  assign rq_next  = rq_diff[64] ? {rq_shift[64:1], 1'b0} : {rq_diff[64:1], 1'b1};

  // quotient negative when the signs differ, remainder follows the dividend
  assign quot_fixed = (a_neg ^ b_neg) ? (~rq[31:0] + 32'd1) : rq[31:0];
  assign rem_fixed  = a_neg ? (~rq[63:32] + 32'd1) : rq[63:32];

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      step      <= '0;
      res_valid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req_go) begin
            state <= calc;
          end
        end
        calc: begin
          // wraps back to zero after the last step
          step <= step + step_count_t'(1);
          if (last_step) begin
            state <= done;
          end
        end
        done: begin
          if (resp_go) begin
            state     <= idle;
            res_valid <= 1'b0;
          end else begin
            res_valid <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      a_neg   <= signed_fn && req_a[31];
      b_neg   <= signed_fn && req_b[31];
      rq      <= {33'b0, a_mag};
      divisor <= {1'b0, b_mag, 32'b0};
    end else if (state == calc) begin
      rq <= rq_next;
    end
    // first done cycle: sign fixup into the response register
    if ((state == done) && !res_valid) begin
      result <= {rem_fixed, quot_fixed};
    end
  end

  // step counter rests at zero whenever the engine is not iterating
  a_step_zero_outside_calc: assert property (@(posedge clk) disable iff (reset)
    (state != calc) |-> (step == '0));

  // a response is only offered while the FSM sits in done
  a_val_only_in_done: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (state == done));

endmodule

`default_nettype wire

/* imuldiv_route.sv */
// steers requests to the multiply or divide engine by function code
// an order queue of engine-select bits returns responses in request order
`default_nettype none

module imuldiv_route #(
  parameter int order_depth = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_msg_pkg::muldiv_fn_t req_fn,
  input  logic                        req_val,
  output logic                        req_rdy,
  output logic                        mul_req_val,
  input  logic                        mul_req_rdy,
  output logic                        div_req_val,
  input  logic                        div_req_rdy,
  input  imuldiv_msg_pkg::result_t    mul_resp_result,
  input  logic                        mul_resp_val,
  output logic                        mul_resp_rdy,
  input  imuldiv_msg_pkg::result_t    div_resp_result,
  input  logic                        div_resp_val,
  output logic                        div_resp_rdy,
  output imuldiv_msg_pkg::result_t    resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_msg_pkg::*;

  localparam int ptr_w = $clog2(order_depth);
  localparam int cnt_w = $clog2(order_depth + 1);

  // one bit per outstanding request, 1 = divider
  logic             order_q [order_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  logic             is_mul;
  logic             full;
  logic             empty;
  logic             head_div;
  logic             push;
  logic             pop;

  // ----------------------------------------------------------
  // request side
  // ----------------------------------------------------------

  assign is_mul = (req_fn == fn_mul);
  assign full   = (count == cnt_w'(order_depth));
  assign empty  = (count == '0);

  // full queue blocks both engines, else the selected engine decides
  assign req_rdy     = !full && (is_mul ? mul_req_rdy : div_req_rdy);
  assign mul_req_val = req_val && !full && is_mul;
  assign div_req_val = req_val && !full && !is_mul;

  // ----------------------------------------------------------
  // response side
  // ----------------------------------------------------------

  // only the engine at the head may hand over its response
  assign head_div     = order_q[rd_ptr];
  assign resp_val     = !empty && (head_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_div ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = resp_rdy && !empty && !head_div;
  assign div_resp_rdy = resp_rdy && !empty && head_div;

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  // circular pointers, wrap at order_depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(order_depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(order_depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
      end
      if (push && !pop) begin
        count <= count + cnt_w'(1);
      end else if (pop && !push) begin
        count <= count - cnt_w'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= !is_mul;
    end
  end

  // an engine response always has a queue entry behind it, so a pop never hits empty
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val || div_resp_val) |-> !empty);

  // each entry belongs to a busy engine, so a full queue leaves neither engine ready
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    full |-> (!mul_req_rdy && !div_req_rdy));

endmodule

`default_nettype wire

/* imuldiv_unit.sv */
// iterative multiply/divide unit, top level
// one request and one response valid/ready channel, two engines behind a router
`default_nettype none

module imuldiv_unit #(
  parameter int order_depth = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_msg_pkg::muldiv_fn_t req_fn,
  input  imuldiv_msg_pkg::operand_t   req_a,
  input  imuldiv_msg_pkg::operand_t   req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_msg_pkg::result_t    resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_msg_pkg::*;

  // engine request handshakes
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    div_req_val;
  logic    div_req_rdy;

  // engine responses
  result_t mul_resp_result;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t div_resp_result;
  logic    div_resp_val;
  logic    div_resp_rdy;

  imuldiv_route #(
    .order_depth (order_depth)
  ) route_i (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .mul_resp_result (mul_resp_result),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_result (div_resp_result),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy),
    .resp_result     (resp_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy)
  );

  // operands fan out to both engines, only the selected one sees req_val
  imuldiv_mul_iter mul_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  imuldiv_div_iter div_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

endmodule

`default_nettype wire

/* imuldiv_tb.sv */
// self-checking testbench for the iterative muldiv unit
// drives requests through the valid/ready handshake and checks every response in order
`default_nettype none

module imuldiv_tb;

  import imuldiv_msg_pkg::*;

  localparam int order_depth  = 2;
  localparam int resp_latency = 33;
  localparam int rdy_limit    = 400;
  localparam int drain_limit  = 2000;
  localparam int lat_limit    = 100;

  logic       clk;
  logic       reset;
  muldiv_fn_t req_fn;
  operand_t   req_a;
  operand_t   req_b;
  logic       req_val;
  logic       req_rdy;
  result_t    resp_result;
  logic       resp_val;
  logic       resp_rdy;

  // random resp_rdy while set
  logic       backpressure;

  // expected responses in request order, plus the request for error lines
  result_t    exp_q [$];
  muldiv_fn_t fn_q [$];
  operand_t   a_q [$];
  operand_t   b_q [$];

  int         mismatch_count;
  int         other_errors;
  int         checked;

  muldiv_fn_t div_fns [4] = '{fn_div, fn_divu, fn_rem, fn_remu};

  imuldiv_unit #(
    .order_depth (order_depth)
  ) imuldiv_unit_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // mul: full signed product
  // div/rem: {remainder, quotient} over magnitudes, then sign fix for signed codes
  function automatic result_t ref_result(input muldiv_fn_t fn, input operand_t a,
                                         input operand_t b);
    logic signed [63:0] prod;
    logic               sgn;
    operand_t           a_mag;
    operand_t           b_mag;
    operand_t           q;
    operand_t           r;
    if (fn == fn_mul) begin
      prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      return prod;
    end
    sgn   = (fn == fn_div) || (fn == fn_rem);
    a_mag = (sgn && a[31]) ? -a : a;
    b_mag = (sgn && b[31]) ? -b : b;
    // divide by zero: all-ones quotient, dividend left as remainder
    if (b_mag == 0) begin
      q = '1;
      r = a_mag;
    end else begin
      q = a_mag / b_mag;
      r = a_mag % b_mag;
    end
    if (sgn && (a[31] ^ b[31])) begin
      q = -q;
    end
    if (sgn && a[31]) begin
      r = -r;
    end
    return {r, q};
  endfunction

  // small to full-size magnitude with a random sign
  function automatic operand_t rand_divisor();
    operand_t mag;
    mag = $urandom >> ($urandom % 32);
    if (($urandom % 2) != 0) begin
      mag = -mag;
    end
    return mag;
  endfunction

  // ------------------------------------------------------------
  // run control and driver tasks
  // ------------------------------------------------------------

  task automatic end_run();
    $display("responses checked %0d, mismatches %0d, other errors %0d",
             checked, mismatch_count, other_errors);
    if ((mismatch_count == 0) && (other_errors == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // called 2 units after a rising edge, returns 2 units after the accepting edge
  task automatic send_request(input muldiv_fn_t fn, input operand_t a, input operand_t b);
    int waited;
    waited  = 0;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    @(negedge clk);
    while (!req_rdy && (waited < rdy_limit)) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      $display("Timeout at %0t: request %s was not accepted within %0d cycles",
               $time, fn.name(), rdy_limit);
      other_errors++;
    end else begin
      // inputs hold until the next edge, so the transfer is certain
      exp_q.push_back(ref_result(fn, a, b));
      fn_q.push_back(fn);
      a_q.push_back(a);
      b_q.push_back(b);
    end
    @(posedge clk);
    #2;
    req_val = 1'b0;
  endtask

  // wait until every expected response has been seen
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0) && (waited < drain_limit)) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout at %0t: %0d responses still outstanding after %0d cycles",
               $time, exp_q.size(), drain_limit);
      other_errors++;
    end
    @(posedge clk);
    #2;
  endtask

  // single request with resp_rdy high, counts edges until resp_val rises
  task automatic check_latency(input muldiv_fn_t fn, input operand_t a, input operand_t b);
    int   edges;
    logic seen;
    edges = 0;
    seen  = 1'b0;
    send_request(fn, a, b);
    while (!seen && (edges < lat_limit)) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      seen = resp_val;
    end
    if (!seen) begin
      $display("Timeout at %0t: no response to %s within %0d cycles",
               $time, fn.name(), lat_limit);
      other_errors++;
    end else begin
      if (edges != resp_latency) begin
        $display("Mismatch at %0t: resp_val latency expected %0d got %0d",
                 $time, resp_latency, edges);
        mismatch_count++;
      end
      wait_drain();
    end
  endtask

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------

  always begin
    @(posedge clk);
    #2;
    if (backpressure) begin
      resp_rdy = (($urandom % 2) != 0);
    end else begin
      resp_rdy = 1'b1;
    end
  end

  // each transfer must match the oldest expected entry
  always @(negedge clk) begin : check_responses
    result_t    exp_val;
    muldiv_fn_t fn;
    operand_t   a;
    operand_t   b;
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: response arrived with no request outstanding", $time);
        other_errors++;
      end else begin
        exp_val = exp_q.pop_front();
        fn      = fn_q.pop_front();
        a       = a_q.pop_front();
        b       = b_q.pop_front();
        checked++;
        if (resp_result !== exp_val) begin
          $display("Mismatch at %0t: resp_result expected %h got %h (%s a=%h b=%h)",
                   $time, exp_val, resp_result, fn.name(), a, b);
          mismatch_count++;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin
    void'($urandom(32'hcaa4));
    clk            = 1'b0;
    reset          = 1'b1;
    req_fn         = fn_mul;
    req_a          = '0;
    req_b          = '0;
    req_val        = 1'b0;
    resp_rdy       = 1'b1;
    backpressure   = 1'b0;
    mismatch_count = 0;
    other_errors   = 0;
    checked        = 0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;

    // idle handshake state right after reset
    @(negedge clk);
    if (req_rdy !== 1'b1) begin
      $display("Mismatch at %0t: req_rdy expected 1 got %b", $time, req_rdy);
      mismatch_count++;
    end
    if (resp_val !== 1'b0) begin
      $display("Mismatch at %0t: resp_val expected 0 got %b", $time, resp_val);
      mismatch_count++;
    end
    @(posedge clk);
    #2;

    // signed multiply, corner values first
    send_request(fn_mul, 32'h8000_0000, 32'h8000_0000);
    send_request(fn_mul, 32'h8000_0000, 32'hffff_ffff);
    send_request(fn_mul, 32'h8000_0000, 32'h0000_0001);
    send_request(fn_mul, 32'hffff_ffff, 32'hffff_ffff);
    send_request(fn_mul, 32'hffff_fff9, 32'd3);
    send_request(fn_mul, 32'd12345, 32'hffff_fd5a);
    for (int i = 0; i < 12; i++) begin
      send_request(fn_mul, $urandom, $urandom);
    end
    wait_drain();

    // signed divide and remainder, every sign mix
    for (int k = 0; k < 2; k++) begin
      send_request(div_fns[2 * k], 32'hffff_fff9, 32'd2);
      send_request(div_fns[2 * k], 32'd7, 32'hffff_fffe);
      send_request(div_fns[2 * k], 32'hffff_fff9, 32'hffff_fffe);
      send_request(div_fns[2 * k], 32'h8000_0000, 32'hffff_ffff);
      send_request(div_fns[2 * k], 32'h8000_0000, 32'd3);
      for (int i = 0; i < 10; i++) begin
        send_request(div_fns[2 * k], $urandom, rand_divisor());
      end
    end
    wait_drain();

    // unsigned with the top bit set, then division by zero
    send_request(fn_divu, 32'hffff_ffff, 32'h8000_0000);
    send_request(fn_remu, 32'h8000_0001, 32'hffff_fffe);
    send_request(fn_divu, 32'hffff_fff0, 32'd7);
    for (int i = 0; i < 8; i++) begin
      send_request(div_fns[1 + 2 * (i % 2)], $urandom | 32'h8000_0000, rand_divisor());
    end
    send_request(fn_div, 32'h8000_0005, 32'd0);
    send_request(fn_rem, 32'hffff_fff7, 32'd0);
    send_request(fn_divu, 32'd123, 32'd0);
    send_request(fn_remu, 32'hffff_ffff, 32'd0);
    send_request(fn_div, 32'd0, 32'd0);
    wait_drain();

    // alternate engines back to back under random back-pressure
    @(negedge clk);
    backpressure = 1'b1;
    @(posedge clk);
    #2;
    for (int i = 0; i < 40; i++) begin
      if ((i % 2) == 0) begin
        send_request(fn_mul, $urandom, $urandom);
      end else begin
        send_request(div_fns[(i / 2) % 4], $urandom, rand_divisor());
      end
    end
    wait_drain();
    @(negedge clk);
    backpressure = 1'b0;
    @(posedge clk);
    #2;

    // exact response timing for each engine
    check_latency(fn_mul, 32'hffff_fffd, 32'd11);
    check_latency(fn_divu, 32'hdead_beef, 32'd17);

    if (exp_q.size() != 0) begin
      $display("Error at %0t: %0d expected responses never arrived", $time, exp_q.size());
      other_errors++;
    end
    end_run();
  end

endmodule

`default_nettype wire

/* imuldiv.f */
imuldiv_msg_pkg.sv
imuldiv_ctrl_pkg.sv
imuldiv_mul_iter.sv
imuldiv_div_iter.sv
imuldiv_route.sv
imuldiv_unit.sv
imuldiv_tb.sv

/* Makefile */
# Verilator build and run for the muldiv unit testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
FILELIST  ?= imuldiv.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, so a failing run returns a failing status
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
